/* common/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Reorder buffer depth with every slot usable
`define ROB_SIZE 16

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// Tags that are either free or held by in-flight instructions
`define FREE_SIZE (`PHYS_REGS - `ARCH_REGS)

// Derived widths
`define ARCH_W     $clog2(`ARCH_REGS)
`define PHYS_W     $clog2(`PHYS_REGS)
`define ROB_IDX_W  $clog2(`ROB_SIZE)
`define ROB_CNT_W  ($clog2(`ROB_SIZE) + 1)   // Counts 0 to ROB_SIZE
`define FREE_IDX_W $clog2(`FREE_SIZE)
`define FREE_CNT_W ($clog2(`FREE_SIZE) + 1)  // Counts 0 to FREE_SIZE

`endif

/* common/rename_pkg.sv */
`include "core_settings.svh"

// Register naming shared by the map table, free list and ROB
package rename_pkg;

	// Architectural register number
	typedef logic [`ARCH_W-1:0] arch_reg_t;

	// Physical register tag that the CDB also carries
	typedef logic [`PHYS_W-1:0] phys_reg_t;

	// One instruction offered at dispatch
	typedef struct packed {
		arch_reg_t arch_dest;  // Destination to rename
		logic      halt;       // Only reported when it retires
	} dispatch_t;

endpackage

/* common/rob_pkg.sv */
`include "core_settings.svh"

// Reorder buffer records and pointers
package rob_pkg;

	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;    // Slot index
	typedef logic [`ROB_CNT_W-1:0] rob_count_t;  // Occupancy

	// One ROB slot
	typedef struct packed {
		rename_pkg::phys_reg_t t_new;      // Tag written by this instruction
		rename_pkg::phys_reg_t t_old;      // Previous mapping, freed at retire
		rename_pkg::arch_reg_t arch_dest;
		logic                  halt;
		logic                  busy;       // Slot holds a live instruction
		logic                  ready;      // Result seen on the CDB
	} rob_entry_t;

	// What leaves the head each retire cycle
	typedef struct packed {
		rename_pkg::arch_reg_t arch_dest;
		rename_pkg::phys_reg_t t_new;      // Becomes architectural
		rename_pkg::phys_reg_t t_old;      // Goes back to the free list
		logic                  halt;
	} retire_t;

endpackage

/* design/free_list.sv */
`include "core_settings.svh"

// Ring of free physical tags with a second pointer at the retire point
module free_list (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  pop,       // Dispatch takes free_tag
	input  logic                  push,      // Retire returns a tag
	input  rename_pkg::phys_reg_t push_tag,
	output rename_pkg::phys_reg_t free_tag,
	output logic                  empty
);

	typedef logic [`FREE_IDX_W-1:0] free_idx_t;
	typedef logic [`FREE_CNT_W-1:0] free_count_t;

	rename_pkg::phys_reg_t slots [`FREE_SIZE];
	free_idx_t             rd_ptr_q;    // Next tag to hand out
	free_idx_t             ret_ptr_q;   // Oldest in-flight slot
	free_idx_t             ret_ptr_next;
	free_count_t           count_q;

	assign free_tag     = slots[rd_ptr_q];
	assign empty        = (count_q == '0);
	assign ret_ptr_next = push ? ret_ptr_q + free_idx_t'(1) : ret_ptr_q;  // Ring wraps at 32

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `FREE_SIZE; i++)
				slots[i] <= rename_pkg::phys_reg_t'(`ARCH_REGS + i);  // Tags 32 to 63
			rd_ptr_q  <= '0;
			ret_ptr_q <= '0;
			count_q   <= free_count_t'(`FREE_SIZE);
		end else begin
			// Slot held the retiring T_new that is now architectural
			if (push)
				slots[ret_ptr_q] <= push_tag;
			ret_ptr_q <= ret_ptr_next;
			if (flush) begin
				rd_ptr_q <= ret_ptr_next;                 // Squashed tags come back in order
				count_q  <= free_count_t'(`FREE_SIZE);
			end else begin
				if (pop)
					rd_ptr_q <= rd_ptr_q + free_idx_t'(1);
				count_q <= count_q + free_count_t'(push) - free_count_t'(pop);
			end
		end
	end

endmodule

/* design/map_table.sv */
`include "core_settings.svh"

// Speculative and architectural register maps
module map_table (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  rename,
	input  logic                  commit,
	input  rename_pkg::arch_reg_t rename_arch,
	input  rename_pkg::arch_reg_t commit_arch,
	input  rename_pkg::phys_reg_t rename_tag,
	input  rename_pkg::phys_reg_t commit_tag,
	output rename_pkg::phys_reg_t t_old
);

	rename_pkg::phys_reg_t spec_map [`ARCH_REGS];
	rename_pkg::phys_reg_t arch_map [`ARCH_REGS];
	rename_pkg::phys_reg_t arch_next [`ARCH_REGS];  // Arch map with this cycle's commit

	// Read before the rename write lands
	assign t_old = spec_map[rename_arch];

	always_comb begin
		arch_next = arch_map;
		if (commit)
			arch_next[commit_arch] = commit_tag;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			// Identity map that sends r to tag r
			for (int i = 0; i < `ARCH_REGS; i++) begin
				spec_map[i] <= rename_pkg::phys_reg_t'(i);
				arch_map[i] <= rename_pkg::phys_reg_t'(i);
			end
		end else begin
			arch_map <= arch_next;
			if (flush)
				spec_map <= arch_next;                 // Roll back to retired state
			else if (rename)
				spec_map[rename_arch] <= rename_tag;
		end
	end

endmodule

/* design/rename_core.sv */
// Rename back end top with map table, free list and reorder buffer
module rename_core (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  dispatch_valid,
	input  rename_pkg::dispatch_t dispatch,
	output logic                  dispatch_ready,
	output rename_pkg::phys_reg_t dispatch_tag,       // T_new
	output rob_pkg::rob_idx_t     dispatch_rob_index,
	input  logic                  cdb_valid,
	input  rename_pkg::phys_reg_t cdb_tag,
	output logic                  retire_valid,
	output rob_pkg::retire_t      retire
);

	logic                  dispatch_fire;
	logic                  retire_fire;    // Retire that is not being flushed away
	logic                  rob_full;
	logic                  free_empty;
	rename_pkg::phys_reg_t t_old;
	rob_pkg::rob_entry_t   entry_data;

	assign dispatch_ready = !rob_full && !free_empty;
	assign dispatch_fire  = dispatch_valid && dispatch_ready;  // Pop, rename and ROB write
	assign retire_fire    = retire_valid && !flush;

	// New ROB record that is busy and waits on its tag
	always_comb begin
		entry_data.t_new     = dispatch_tag;
		entry_data.t_old     = t_old;
		entry_data.arch_dest = dispatch.arch_dest;
		entry_data.halt      = dispatch.halt;
		entry_data.busy      = 1'b1;
		entry_data.ready     = 1'b0;
	end

	map_table u_map (
		.clock (clock), .rst (rst), .flush (flush),
		.rename (dispatch_fire), .commit (retire_fire),
		.rename_arch (dispatch.arch_dest), .commit_arch (retire.arch_dest),
		.rename_tag (dispatch_tag), .commit_tag (retire.t_new),
		.t_old (t_old)
	);

	free_list u_free (
		.clock (clock), .rst (rst), .flush (flush),
		.pop (dispatch_fire), .push (retire_fire), .push_tag (retire.t_old),
		.free_tag (dispatch_tag), .empty (free_empty)
	);

	rob u_rob (
		.clock (clock), .rst (rst), .flush (flush),
		.dispatch_fire (dispatch_fire), .cdb_valid (cdb_valid),
		.dispatch_data (entry_data), .cdb_tag (cdb_tag),
		.rob_index (dispatch_rob_index), .full (rob_full),
		.retire_valid (retire_valid), .retire (retire)
	);

endmodule

/* rob/rob.sv */
`include "core_settings.svh"

// Reorder buffer built from the allocator, slot array and retire unit
module rob (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  dispatch_fire,
	input  logic                  cdb_valid,
	input  rob_pkg::rob_entry_t   dispatch_data,
	input  rename_pkg::phys_reg_t cdb_tag,
	output rob_pkg::rob_idx_t     rob_index,
	output logic                  full,
	output logic                  retire_valid,
	output rob_pkg::retire_t      retire
);

	logic [`ROB_SIZE-1:0] write;       // One-hot from the allocator
	logic [`ROB_SIZE-1:0] clear;       // One-hot from the retire unit
	rob_pkg::rob_entry_t  write_data;
	rob_pkg::rob_entry_t  entries [`ROB_SIZE];

	rob_alloc u_alloc (
		.clock         (clock),
		.rst           (rst),
		.flush         (flush),
		.dispatch_fire (dispatch_fire),
		.retire_valid  (retire_valid),
		.dispatch_data (dispatch_data),
		.write         (write),
		.write_data    (write_data),
		.tail          (rob_index),
		.full          (full)
	);

	// Each slot snoops the CDB on its own
	for (genvar i = 0; i < `ROB_SIZE; i++) begin : g_entry
		rob_entry u_entry (
			.clock      (clock),
			.rst        (rst),
			.flush      (flush),
			.write      (write[i]),
			.clear      (clear[i]),
			.cdb_valid  (cdb_valid),
			.write_data (write_data),
			.cdb_tag    (cdb_tag),
			.entry      (entries[i])
		);
	end

	rob_retire u_retire (
		.clock        (clock),
		.rst          (rst),
		.flush        (flush),
		.entries      (entries),
		.clear        (clear),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

endmodule

/* rob/rob_alloc.sv */
`include "core_settings.svh"

// Tail side of the ROB, occupancy and the slot write strobes
module rob_alloc (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  dispatch_fire,
	input  logic                  retire_valid,
	input  rob_pkg::rob_entry_t   dispatch_data,
	output logic [`ROB_SIZE-1:0]  write,
	output rob_pkg::rob_entry_t   write_data,
	output rob_pkg::rob_idx_t     tail,
	output logic                  full
);

	rob_pkg::rob_count_t count_q;

	assign write_data = dispatch_data;  // Same record goes to every slot
	assign full       = (count_q == rob_pkg::rob_count_t'(`ROB_SIZE));

	// One-hot decode of the tail
	always_comb begin
		write = '0;
		if (dispatch_fire)
			write[tail] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			tail    <= '0;
			count_q <= '0;
		end else begin
			if (dispatch_fire)
				tail <= (tail == rob_pkg::rob_idx_t'(`ROB_SIZE - 1)) ?
					'0 : tail + rob_pkg::rob_idx_t'(1);
			// Both at once leaves the count as it is
			case ({dispatch_fire, retire_valid})
				2'b10:   count_q <= count_q + rob_pkg::rob_count_t'(1);
				2'b01:   count_q <= count_q - rob_pkg::rob_count_t'(1);
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

/* rob/rob_entry.sv */
// One ROB slot with its own CDB tag compare
module rob_entry (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  write,       // Allocate at the tail
	input  logic                  clear,       // Retire at the head
	input  logic                  cdb_valid,
	input  rob_pkg::rob_entry_t   write_data,
	input  rename_pkg::phys_reg_t cdb_tag,
	output rob_pkg::rob_entry_t   entry
);

	logic cdb_hit;

	// Only a waiting slot listens to the bus
	assign cdb_hit = cdb_valid && entry.busy && !entry.ready &&
		(entry.t_new == cdb_tag);

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			// Squash the slot
			entry.busy  <= 1'b0;
			entry.ready <= 1'b0;
		end else if (write) begin
			entry <= write_data;         // Comes in busy and not ready
		end else begin
			if (clear)
				entry.busy <= 1'b0;      // Head has left
			if (cdb_hit)
				entry.ready <= 1'b1;     // Visible to retire next cycle
		end
	end

endmodule

/* rob/rob_retire.sv */
`include "core_settings.svh"

// Head side of the ROB that retires ready entries in order
module rob_retire (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  flush,
	input  rob_pkg::rob_entry_t   entries [`ROB_SIZE],
	output logic [`ROB_SIZE-1:0]  clear,
	output logic                  retire_valid,
	output rob_pkg::retire_t      retire
);

	rob_pkg::rob_idx_t   head_q;
	rob_pkg::rob_entry_t head_entry;

	assign head_entry   = entries[head_q];
	assign retire_valid = head_entry.busy && head_entry.ready;  // From registers only

	// Record for the free list and architectural map
	always_comb begin
		retire.arch_dest = head_entry.arch_dest;
		retire.t_new     = head_entry.t_new;
		retire.t_old     = head_entry.t_old;
		retire.halt      = head_entry.halt;
	end

	// Free the head slot as it retires
	always_comb begin
		clear = '0;
		if (retire_valid)
			clear[head_q] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (rst || flush)
			head_q <= '0;
		else if (retire_valid)
			head_q <= (head_q == rob_pkg::rob_idx_t'(`ROB_SIZE - 1)) ?
				'0 : head_q + rob_pkg::rob_idx_t'(1);
	end

endmodule

/* testbench/rename_core_tb.sv */
`include "core_settings.svh"

// Random dispatch, CDB and flush traffic against a queue-based model of the rename back end
module rename_core_tb;

	logic                  clock;
	logic                  rst;
	logic                  flush;
	logic                  dispatch_valid;
	rename_pkg::dispatch_t dispatch;
	logic                  dispatch_ready;
	rename_pkg::phys_reg_t dispatch_tag;
	rob_pkg::rob_idx_t     dispatch_rob_index;
	logic                  cdb_valid;
	rename_pkg::phys_reg_t cdb_tag;
	logic                  retire_valid;
	rob_pkg::retire_t      retire;

	rob_pkg::rob_entry_t   rob_q [$];              // In flight, oldest first
	rename_pkg::phys_reg_t free_q [$];             // Next tag at the front
	rename_pkg::phys_reg_t spec_map [`ARCH_REGS];
	rename_pkg::phys_reg_t arch_map [`ARCH_REGS];
	rob_pkg::rob_idx_t     tail;                   // Wraps at 16 by width

	integer seed = 32'hd7b8763f;
	int     checks = 0;
	int     errors = 0;
	int     mark;

	rename_core i_dut (
		.clock              (clock),
		.rst                (rst),
		.flush              (flush),
		.dispatch_valid     (dispatch_valid),
		.dispatch           (dispatch),
		.dispatch_ready     (dispatch_ready),
		.dispatch_tag       (dispatch_tag),
		.dispatch_rob_index (dispatch_rob_index),
		.cdb_valid          (cdb_valid),
		.cdb_tag            (cdb_tag),
		.retire_valid       (retire_valid),
		.retire             (retire)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("mismatch at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task reset_model;
		rob_q.delete();
		free_q.delete();
		for (int i = 0; i < `FREE_SIZE; i++)
			free_q.push_back(rename_pkg::phys_reg_t'(`ARCH_REGS + i));  // 32 up to 63
		for (int i = 0; i < `ARCH_REGS; i++) begin
			spec_map[i] = rename_pkg::phys_reg_t'(i);
			arch_map[i] = rename_pkg::phys_reg_t'(i);
		end
		tail = '0;
	endtask

	// Compare mid-cycle and then apply this cycle's strobes to the model
	always @(negedge clock) begin : model
		bit                    exp_ready;
		bit                    exp_retire;
		rob_pkg::retire_t      exp_ret;
		rob_pkg::rob_entry_t   e;
		rename_pkg::phys_reg_t nq [$];
		if (rst) begin
			reset_model();
		end else begin
			exp_ready  = (rob_q.size() < `ROB_SIZE) && (free_q.size() != 0);
			exp_retire = (rob_q.size() != 0) && rob_q[0].ready;
			check(dispatch_ready == exp_ready,
				$sformatf("dispatch_ready %0b, expected %0b", dispatch_ready, exp_ready));
			if (free_q.size() != 0)
				check(dispatch_tag == free_q[0],
					$sformatf("dispatch_tag %0d, expected %0d", dispatch_tag, free_q[0]));
			check(dispatch_rob_index == tail,
				$sformatf("rob index %0d, expected %0d", dispatch_rob_index, tail));
			check(retire_valid == exp_retire,
				$sformatf("retire_valid %0b, expected %0b", retire_valid, exp_retire));
			if (exp_retire) begin
				exp_ret.arch_dest = rob_q[0].arch_dest;
				exp_ret.t_new     = rob_q[0].t_new;
				exp_ret.t_old     = rob_q[0].t_old;   // Spec map at dispatch time
				exp_ret.halt      = rob_q[0].halt;
				check(retire == exp_ret,
					$sformatf("retire record %h, expected %h", retire, exp_ret));
			end
			if (flush) begin
				// Squashed tags go back in front of the free ones in dispatch order
				nq.delete();
				foreach (rob_q[i])
					nq.push_back(rob_q[i].t_new);
				foreach (free_q[i])
					nq.push_back(free_q[i]);
				free_q = nq;
				rob_q.delete();
				spec_map = arch_map;
				tail = '0;
			end else begin
				if (exp_retire) begin
					e = rob_q.pop_front();
					arch_map[e.arch_dest] = e.t_new;
					free_q.push_back(e.t_old);
				end
				if (cdb_valid)
					foreach (rob_q[i])
						if (rob_q[i].t_new == cdb_tag) begin
							e = rob_q[i];
							e.ready = 1'b1;
							rob_q[i] = e;
						end
				if (dispatch_valid && exp_ready) begin
					e.t_new     = free_q.pop_front();
					e.t_old     = spec_map[dispatch.arch_dest];
					e.arch_dest = dispatch.arch_dest;
					e.halt      = dispatch.halt;
					e.busy      = 1'b1;
					e.ready     = 1'b0;   // Written after any CDB this cycle
					rob_q.push_back(e);
					spec_map[e.arch_dest] = e.t_new;
					tail = tail + rob_pkg::rob_idx_t'(1);
				end
			end
		end
	end

	task step;
		@(posedge clock);
		#5;                                  // Inputs change just after the edge
	endtask

	task drive_dispatch(input bit valid);
		dispatch_valid     = valid;
		dispatch.arch_dest = rename_pkg::arch_reg_t'($random(seed));
		dispatch.halt      = (($random(seed) & 15) == 0);
	endtask

	// Mostly live tags and now and then one that nothing waits on
	task drive_cdb_random;
		int k;
		cdb_valid = 1'b0;
		if (rob_q.size() != 0 && ($random(seed) & 1)) begin
			k         = $unsigned($random(seed)) % rob_q.size();
			cdb_valid = 1'b1;
			cdb_tag   = rob_q[k].t_new;
		end else if (($random(seed) & 7) == 0) begin
			cdb_valid = 1'b1;
			cdb_tag   = rename_pkg::phys_reg_t'($random(seed));
		end
	endtask

	// Broadcast waiting tags until the ROB is empty
	task drain(input int limit);
		int n;
		n = 0;
		dispatch_valid = 1'b0;
		flush          = 1'b0;
		while (rob_q.size() != 0 && n < limit) begin
			cdb_valid = 1'b0;
			foreach (rob_q[i])
				if (!rob_q[i].ready && !cdb_valid) begin
					cdb_valid = 1'b1;
					cdb_tag   = rob_q[i].t_new;
				end
			n++;
			step();
		end
		cdb_valid = 1'b0;
		if (rob_q.size() != 0) begin
			$display("timeout: ROB still holds %0d entries after %0d cycles", rob_q.size(), n);
			errors++;
		end
	endtask

	task report(input string name, input int start);
		$display("%s: %0d errors", name, errors - start);
	endtask

	initial begin
		rst            = 1'b1;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		cdb_valid      = 1'b0;
		cdb_tag        = '0;
		repeat (5) step();
		rst = 1'b0;

		// First tags and indices straight after reset
		mark = errors;
		repeat (4) begin
			drive_dispatch(1'b1);
			step();
		end
		drain(100);
		report("reset", mark);

		// Fill all 16 slots and keep pushing while full
		mark = errors;
		repeat (20) begin
			drive_dispatch(1'b1);
			step();
		end
		drain(100);
		report("full rob", mark);

		// Mixed traffic with occasional flushes
		mark = errors;
		repeat (800) begin
			drive_dispatch(($random(seed) & 3) != 0);
			drive_cdb_random();
			flush = ($unsigned($random(seed)) % 40) == 0;
			step();
		end
		drain(200);
		report("random", mark);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+common
common/rename_pkg.sv
common/rob_pkg.sv
rob/rob_entry.sv
rob/rob_alloc.sv
rob/rob_retire.sv
rob/rob.sv
design/free_list.sv
design/map_table.sv
design/rename_core.sv
testbench/rename_core_tb.sv
